/* cpu16_pkg.sv */
package cpu16_pkg;

	typedef logic [15:0] uword;      // Data word and byte address
	typedef logic [15:0] instr_t;
	typedef logic [3:0]  reg_addr_t;
	typedef logic [3:0]  opcode_t;
	typedef logic [3:0]  alu_op_t;
	typedef logic [1:0]  fwd_sel_t;

	// Opcodes in bits 15:12, anything else decodes as a no-op
	localparam opcode_t OP_ALU  = 4'h0;
	localparam opcode_t OP_LI   = 4'h1;
	localparam opcode_t OP_ADDI = 4'h2;
	localparam opcode_t OP_LW   = 4'h3;
	localparam opcode_t OP_SW   = 4'h4;
	localparam opcode_t OP_BEQ  = 4'h5;
	localparam opcode_t OP_BNE  = 4'h6;
	localparam opcode_t OP_JMP  = 4'h7;
	localparam opcode_t OP_HALT = 4'hf;

	// Same codes as the func field of ALU instructions
	localparam alu_op_t ALU_ADD = 4'd0;
	localparam alu_op_t ALU_SUB = 4'd1;
	localparam alu_op_t ALU_AND = 4'd2;
	localparam alu_op_t ALU_OR  = 4'd3;
	localparam alu_op_t ALU_XOR = 4'd4;
	localparam alu_op_t ALU_SLL = 4'd5;
	localparam alu_op_t ALU_SRL = 4'd6;
	localparam alu_op_t ALU_SLT = 4'd7; // Signed compare

	localparam fwd_sel_t FWD_RF = 2'd0; // Register file read
	localparam fwd_sel_t FWD_EX = 2'd1; // Execute result
	localparam fwd_sel_t FWD_WB = 2'd2; // Writeback value

	typedef enum logic [1:0] {
		CORE_IDLE,
		CORE_RUN,
		CORE_HALTED
	} core_state_e;

	typedef struct packed {
		logic      valid;
		logic      reg_wr;
		logic      mem_rd;
		logic      mem_wr;
		alu_op_t   alu_op;
		reg_addr_t dest;
		uword      a;
		uword      b;
		uword      st_data;  // r1 value for SW
	} dec_ex_t;

	typedef struct packed {
		logic      valid;
		logic      reg_wr;
		logic      mem_rd;
		logic      mem_wr;
		reg_addr_t dest;
		uword      result;   // ALU value or memory address
		uword      st_data;
	} ex_mem_t;

	typedef struct packed {
		logic      valid;
		reg_addr_t addr;
		uword      data;
	} wb_t;

endpackage

/* cpu16_alu.sv */
`timescale 1ns/100ps

module cpu16_alu import cpu16_pkg::*; (
	input  alu_op_t op,
	input  uword    a,
	input  uword    b,
	output uword    y
);
	logic [3:0] shamt;
	logic       lt;

	assign shamt = b[3:0];                     // Only low 4 bits shift
	assign lt    = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			ALU_ADD: y = a + b;
			ALU_SUB: y = a - b;
			ALU_AND: y = a & b;
			ALU_OR:  y = a | b;
			ALU_XOR: y = a ^ b;
			ALU_SLL: y = a << shamt;
			ALU_SRL: y = a >> shamt;           // Logical
			ALU_SLT: y = {15'd0, lt};
			default: y = '0;
		endcase
	end

endmodule

/* cpu16_fetch.sv */
`timescale 1ns/100ps

module cpu16_fetch import cpu16_pkg::*; #(
	parameter int PROG_DEPTH = 64
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          run,
	input  logic                          prog_we,
	input  logic [$clog2(PROG_DEPTH)-1:0] prog_addr,
	input  instr_t                        prog_wdata,
	input  logic                          stall,
	input  logic                          taken,
	input  uword                          target,
	input  logic                          halt_seen,
	output uword                          pc,
	output instr_t                        instr,
	output logic                          active,
	output logic                          halted
);
	localparam int PA_W = $clog2(PROG_DEPTH);

	core_state_e state;
	instr_t      prog_mem [PROG_DEPTH];

	// Idle until run, then run until a HALT is decoded
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= CORE_IDLE;
		end else if (state == CORE_IDLE && run) begin
			state <= CORE_RUN;
		end else if (state == CORE_RUN && halt_seen) begin
			state <= CORE_HALTED;  // Left only through reset
		end
	end

	assign active = (state == CORE_RUN);
	assign halted = (state == CORE_HALTED);

	// Holds on stall, idle, halt
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (active && !stall && !halt_seen) begin
			pc <= taken ? target : pc + 16'd2;
		end
	end

	// Load port only usable while the core is not running
	always_ff @(posedge clk) begin
		if (prog_we && !active) begin
			prog_mem[prog_addr] <= prog_wdata;
		end
	end

	assign instr = prog_mem[pc[PA_W:1]];  // Byte PC to word index

endmodule

/* cpu16_regfile.sv */
`timescale 1ns/100ps

module cpu16_regfile import cpu16_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  reg_addr_t ra1,
	input  reg_addr_t ra2,
	input  wb_t       wb,
	output uword      rd1,
	output uword      rd2
);
	uword regs [16];

	// Single write port from writeback
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.valid) begin
			regs[wb.addr] <= wb.data;
		end
	end

	// Asynchronous reads
	// Same-cycle write is covered by forwarding in decode
	assign rd1 = regs[ra1];
	assign rd2 = regs[ra2];

endmodule

/* cpu16_hazard.sv */
`timescale 1ns/100ps

module cpu16_hazard import cpu16_pkg::*; (
	input  reg_addr_t src_a,
	input  reg_addr_t src_b,
	input  logic      use_a,
	input  logic      use_b,
	input  wb_t       ex_fwd,
	input  logic      ex_load,
	input  reg_addr_t ex_dest,
	input  logic      ex_valid,
	input  wb_t       wb,
	output fwd_sel_t  fwd_a,
	output fwd_sel_t  fwd_b,
	output logic      stall
);
	logic load_hit_a;
	logic load_hit_b;

	// Youngest value wins
	function automatic fwd_sel_t pick_src(reg_addr_t src, logic used, wb_t ex, wb_t w);
		if (used && ex.valid && ex.addr == src)
			return FWD_EX;
		if (used && w.valid && w.addr == src)
			return FWD_WB;
		return FWD_RF;
	endfunction

	assign fwd_a = pick_src(src_a, use_a, ex_fwd, wb);
	assign fwd_b = pick_src(src_b, use_b, ex_fwd, wb);

	// Load data not ready until writeback
	assign load_hit_a = use_a && (ex_dest == src_a);
	assign load_hit_b = use_b && (ex_dest == src_b);
	assign stall      = ex_valid && ex_load && (load_hit_a || load_hit_b);

endmodule

/* cpu16_decode.sv */
`timescale 1ns/100ps

module cpu16_decode import cpu16_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      active,
	input  instr_t    instr,
	input  uword      pc,
	input  uword      rd1,
	input  uword      rd2,
	input  fwd_sel_t  fwd_a,
	input  fwd_sel_t  fwd_b,
	input  logic      stall,
	input  wb_t       ex_fwd,
	input  wb_t       wb,
	output reg_addr_t ra1,
	output reg_addr_t ra2,
	output reg_addr_t src_a,
	output reg_addr_t src_b,
	output logic      use_a,
	output logic      use_b,
	output logic      taken,
	output uword      target,
	output logic      halt_seen,
	output dec_ex_t   s1
);
	opcode_t opcode;
	uword    imm4;
	uword    imm8;
	uword    imm12;
	uword    offset;
	uword    op_a;
	uword    op_b;
	logic    uses_a;
	logic    uses_b;
	logic    is_branch;
	logic    is_jump;
	logic    is_halt;
	logic    cond;
	logic    issue;
	dec_ex_t s1_d;

	assign opcode = instr[15:12];
	assign src_a  = instr[11:8];  // r1, also the destination
	assign src_b  = instr[7:4];   // r2
	assign ra1    = src_a;
	assign ra2    = src_b;

	assign imm4  = {{12{instr[3]}}, instr[3:0]};
	assign imm8  = {{8{instr[7]}}, instr[7:0]};
	assign imm12 = {{4{instr[11]}}, instr[11:0]};

	function automatic uword fwd_mux(fwd_sel_t sel, uword rf, uword ex, uword wbv);
		case (sel)
			FWD_EX:  return ex;
			FWD_WB:  return wbv;
			default: return rf;
		endcase
	endfunction

	assign op_a  = fwd_mux(fwd_a, rd1, ex_fwd.data, wb.data);
	assign op_b  = fwd_mux(fwd_b, rd2, ex_fwd.data, wb.data);
	assign issue = active && !stall;

	always_comb begin
		s1_d         = '0;
		s1_d.alu_op  = ALU_ADD;    // Immediates and addresses use add
		s1_d.dest    = src_a;
		s1_d.a       = op_a;
		s1_d.b       = op_b;
		s1_d.st_data = op_a;
		uses_a       = 1'b0;
		uses_b       = 1'b0;
		is_branch    = 1'b0;
		is_jump      = 1'b0;
		is_halt      = 1'b0;
		case (opcode)
			OP_ALU: begin
				s1_d.reg_wr = !instr[3];   // Funcs 8 to 15 do nothing
				s1_d.alu_op = instr[3:0];
				uses_a      = 1'b1;
				uses_b      = 1'b1;
			end
			OP_LI: begin
				s1_d.reg_wr = 1'b1;
				s1_d.a      = '0;          // 0 + imm8
				s1_d.b      = imm8;
			end
			OP_ADDI: begin
				s1_d.reg_wr = 1'b1;
				s1_d.b      = imm8;
				uses_a      = 1'b1;
			end
			OP_LW: begin
				s1_d.reg_wr = 1'b1;
				s1_d.mem_rd = 1'b1;
				s1_d.a      = op_b;        // Base in r2
				s1_d.b      = imm4;
				uses_b      = 1'b1;
			end
			OP_SW: begin
				s1_d.mem_wr = 1'b1;
				s1_d.a      = op_b;
				s1_d.b      = imm4;
				uses_a      = 1'b1;        // Store data
				uses_b      = 1'b1;
			end
			OP_BEQ, OP_BNE: begin
				is_branch = 1'b1;
				uses_a    = 1'b1;
				uses_b    = 1'b1;
			end
			OP_JMP:  is_jump = 1'b1;
			OP_HALT: is_halt = 1'b1;
			default: ;                     // No-op
		endcase
		s1_d.valid = issue && (s1_d.reg_wr || s1_d.mem_wr);  // Others go as bubbles
	end

	assign use_a = active && uses_a;
	assign use_b = active && uses_b;

	// Branches resolve here on forwarded operands
	assign cond      = (op_a == op_b) ^ (opcode == OP_BNE);
	assign taken     = issue && ((is_branch && cond) || is_jump);
	assign offset    = is_branch ? imm4 : imm12;
	assign target    = pc + 16'd2 + {offset[14:0], 1'b0};
	assign halt_seen = active && is_halt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1 <= '0;
		end else begin
			s1 <= s1_d;
		end
	end

endmodule

/* cpu16_execute.sv */
`timescale 1ns/100ps

module cpu16_execute import cpu16_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  dec_ex_t   s1,
	output wb_t       ex_fwd,
	output logic      ex_load,
	output reg_addr_t ex_dest,
	output logic      ex_valid,
	output ex_mem_t   s2
);
	uword    alu_y;
	ex_mem_t s2_d;

	cpu16_alu alu_i (
		.op (s1.alu_op),
		.a  (s1.a),
		.b  (s1.b),
		.y  (alu_y)      // Also the LW and SW address
	);

	// Loads have no data yet so they never forward from here
	assign ex_fwd.valid = s1.valid && s1.reg_wr && !s1.mem_rd;
	assign ex_fwd.addr  = s1.dest;
	assign ex_fwd.data  = alu_y;

	// For the load-use check
	assign ex_load  = s1.mem_rd;
	assign ex_dest  = s1.dest;
	assign ex_valid = s1.valid;

	always_comb begin
		s2_d.valid   = s1.valid;
		s2_d.reg_wr  = s1.reg_wr;
		s2_d.mem_rd  = s1.mem_rd;
		s2_d.mem_wr  = s1.mem_wr;
		s2_d.dest    = s1.dest;
		s2_d.result  = alu_y;
		s2_d.st_data = s1.st_data;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s2 <= '0;
		end else begin
			s2 <= s2_d;
		end
	end

endmodule

/* cpu16_memwb.sv */
`timescale 1ns/100ps

module cpu16_memwb import cpu16_pkg::*; #(
	parameter int DATA_DEPTH = 32
) (
	input  logic    clk,
	input  logic    rst_n,
	input  ex_mem_t s2,
	output wb_t     wb,
	output logic    st_valid,
	output uword    st_addr,
	output uword    st_data
);
	localparam int DA_W = $clog2(DATA_DEPTH);

	uword            dmem [DATA_DEPTH];
	logic [DA_W-1:0] idx;

	assign idx      = s2.result[DA_W-1:0];   // Word address, upper bits ignored
	assign st_valid = s2.valid && s2.mem_wr;
	assign st_addr  = s2.result;
	assign st_data  = s2.st_data;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DATA_DEPTH; i++) begin
				dmem[i] <= '0;
			end
		end else if (st_valid) begin
			dmem[idx] <= s2.st_data;
		end
	end

	// Load data read in the same cycle
	assign wb.valid = s2.valid && s2.reg_wr;
	assign wb.addr  = s2.dest;
	assign wb.data  = s2.mem_rd ? dmem[idx] : s2.result;

endmodule

/* cpu16_top.sv */
`timescale 1ns/100ps

module cpu16_top import cpu16_pkg::*; #(
	parameter int PROG_DEPTH = 64,
	parameter int DATA_DEPTH = 32
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          run,
	input  logic                          prog_we,
	input  logic [$clog2(PROG_DEPTH)-1:0] prog_addr,
	input  instr_t                        prog_wdata,
	output wb_t                           wb,
	output logic                          st_valid,
	output uword                          st_addr,
	output uword                          st_data,
	output logic                          halted
);
	uword      pc;
	uword      target;
	uword      rd1;
	uword      rd2;
	instr_t    instr;
	logic      active;
	logic      taken;
	logic      halt_seen;
	logic      stall;
	logic      use_a;
	logic      use_b;
	logic      ex_load;
	logic      ex_valid;
	reg_addr_t ra1;
	reg_addr_t ra2;
	reg_addr_t src_a;
	reg_addr_t src_b;
	reg_addr_t ex_dest;
	fwd_sel_t  fwd_a;
	fwd_sel_t  fwd_b;
	dec_ex_t   s1;
	ex_mem_t   s2;
	wb_t       ex_fwd;

	cpu16_fetch #(.PROG_DEPTH(PROG_DEPTH)) fetch_i (
		.clk, .rst_n, .run, .prog_we, .prog_addr, .prog_wdata,
		.stall, .taken, .target, .halt_seen,
		.pc, .instr, .active, .halted
	);

	cpu16_regfile regfile_i (
		.clk, .rst_n, .ra1, .ra2, .wb, .rd1, .rd2
	);

	cpu16_hazard hazard_i (
		.src_a, .src_b, .use_a, .use_b, .ex_fwd, .ex_load,
		.ex_dest, .ex_valid, .wb, .fwd_a, .fwd_b, .stall
	);

	// Stage 1
	cpu16_decode decode_i (
		.clk, .rst_n, .active, .instr, .pc, .rd1, .rd2,
		.fwd_a, .fwd_b, .stall, .ex_fwd, .wb,
		.ra1, .ra2, .src_a, .src_b, .use_a, .use_b,
		.taken, .target, .halt_seen, .s1
	);

	// Stage 2
	cpu16_execute execute_i (
		.clk, .rst_n, .s1, .ex_fwd, .ex_load, .ex_dest, .ex_valid, .s2
	);

	// Stage 3
	cpu16_memwb #(.DATA_DEPTH(DATA_DEPTH)) memwb_i (
		.clk, .rst_n, .s2, .wb, .st_valid, .st_addr, .st_data
	);

endmodule

/* cpu16_checker.sv */
`timescale 1ns/100ps

module cpu16_checker import cpu16_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  wb_t  wb,
	input  logic st_valid,
	input  uword st_addr,
	input  uword st_data,
	input  logic halted
);
	wb_t         exp_wr [$];        // Register writes in program order
	logic [31:0] exp_st [$];        // {address, data}
	int          wr_seen      = 0;
	int          wr_base      = 0;  // wr_seen at program start
	int          wr_count     = 0;  // Model's total
	int          halt_age     = 0;  // Cycles since halted rose
	int          mismatches   = 0;
	int          missing      = 0;
	int          extra        = 0;
	int          count_errors = 0;

	task automatic clear_expected();
		exp_wr.delete();
		exp_st.delete();
		wr_base = wr_seen;
	endtask

	task automatic expect_write(reg_addr_t addr, uword data);
		exp_wr.push_back('{valid: 1'b1, addr: addr, data: data});
	endtask

	task automatic expect_store(uword addr, uword data);
		exp_st.push_back({addr, data});
	endtask

	task automatic expect_write_count(int n);
		wr_count = n;
	endtask

	task automatic compare(string name, uword got, uword exp);
		if (got !== exp) begin
			mismatches++;
			$display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	// Called once the pipeline has drained
	task automatic check_complete();
		if (exp_wr.size() != 0 || exp_st.size() != 0) begin
			missing += exp_wr.size() + exp_st.size();
			$display("%0d register writes and %0d stores never appeared",
				exp_wr.size(), exp_st.size());
		end
		if (wr_seen - wr_base != wr_count) begin
			count_errors++;
			$display("Mismatch at %0t: write count is %0d, expected %0d",
				$time, wr_seen - wr_base, wr_count);
		end
	endtask

	// Outputs come from registers, stable here
	always @(negedge clk) begin
		halt_age = halted ? halt_age + 1 : 0;
		if (rst_n && (wb.valid || st_valid) && halt_age > 1) begin
			extra++;
			$display("Event at %0t after the pipeline should have drained", $time);
		end
		if (rst_n && wb.valid) begin
			wr_seen++;
			if (exp_wr.size() == 0) begin
				extra++;
				$display("Unexpected register write r%0d = %h at %0t", wb.addr, wb.data, $time);
			end else begin
				compare("wb.addr", {12'd0, wb.addr}, {12'd0, exp_wr[0].addr});
				compare("wb.data", wb.data, exp_wr[0].data);
				void'(exp_wr.pop_front());
			end
		end
		if (rst_n && st_valid) begin
			if (exp_st.size() == 0) begin
				extra++;
				$display("Unexpected store of %h to %h at %0t", st_data, st_addr, $time);
			end else begin
				compare("st_addr", st_addr, exp_st[0][31:16]);
				compare("st_data", st_data, exp_st[0][15:0]);
				void'(exp_st.pop_front());
			end
		end
	end

endmodule

/* cpu16_assertions.sv */
`timescale 1ns/100ps

module cpu16_assertions import cpu16_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic stall,
	input  logic st_valid,
	input  logic wb_valid,
	input  logic halted,
	input  uword pc
);
	int stall_fails = 0;
	int port_fails  = 0;
	int pc_fails    = 0;
	int halt_fails  = 0;

	// A load-use stall always leaves a bubble behind it
	assert property (@(posedge clk) disable iff (!rst_n) stall |=> !stall)
		else begin
			stall_fails++;
			$error("stall high in two cycles in a row");
		end

	// Store and register write never share a stage 3 slot
	assert property (@(posedge clk) disable iff (!rst_n) !(st_valid && wb_valid))
		else begin
			port_fails++;
			$error("store and register write in the same cycle");
		end

	assert property (@(posedge clk) disable iff (!rst_n) halted |=> $stable(pc))
		else begin
			pc_fails++;
			$error("PC moved while halted");
		end

	// Only reset leaves the halted state
	assert property (@(posedge clk) disable iff (!rst_n) halted |=> halted)
		else begin
			halt_fails++;
			$error("halted fell without reset");
		end

endmodule

bind cpu16_top cpu16_assertions asrt_i (
	.clk      (clk),
	.rst_n    (rst_n),
	.stall    (stall),
	.st_valid (st_valid),
	.wb_valid (wb.valid),
	.halted   (halted),
	.pc       (pc)
);

/* cpu16_tb.sv */
`timescale 1ns/100ps

module cpu16_tb import cpu16_pkg::*; ();
	localparam int PROG_DEPTH = 64;
	localparam int DATA_DEPTH = 32;
	localparam int PA_W       = $clog2(PROG_DEPTH);
	localparam int DA_W       = $clog2(DATA_DEPTH);
	localparam int TIMEOUT    = 2000;   // Cycles allowed per wait
	localparam int STEP_LIMIT = 500;    // Model steps per program

	logic            clk;
	logic            rst_n;
	logic            run;
	logic            prog_we;
	logic [PA_W-1:0] prog_addr;
	instr_t          prog_wdata;
	wb_t             wb;
	logic            st_valid;
	uword            st_addr;
	uword            st_data;
	logic            halted;

	instr_t      prog_words [$];        // All programs back to back
	int          prog_ends  [$];        // One past the last word of each program
	logic [31:0] rng          = 32'd76760;
	int          other_errors = 0;      // Timeouts and model overruns

	cpu16_top #(.PROG_DEPTH(PROG_DEPTH), .DATA_DEPTH(DATA_DEPTH)) cpu16_top_i (.*);

	cpu16_checker checker_i (.clk, .rst_n, .wb, .st_valid, .st_addr, .st_data, .halted);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;         // 8 ns period
	end

	function automatic logic [31:0] next_random();
		rng ^= rng << 13;
		rng ^= rng >> 17;
		rng ^= rng << 5;
		return rng;
	endfunction

	// Instruction encoders
	function automatic instr_t alu_word(alu_op_t func, reg_addr_t r1, reg_addr_t r2);
		return {OP_ALU, r1, r2, func};
	endfunction

	function automatic instr_t imm_word(opcode_t op, reg_addr_t r1, logic [7:0] imm);
		return {op, r1, imm};
	endfunction

	function automatic instr_t rri_word(opcode_t op, reg_addr_t r1, reg_addr_t r2,
			logic [3:0] imm);
		return {op, r1, r2, imm};
	endfunction

	function automatic instr_t jmp_word(logic [11:0] off);
		return {OP_JMP, off};
	endfunction

	task automatic add(instr_t w);
		prog_words.push_back(w);
	endtask

	task automatic end_program();
		prog_ends.push_back(prog_words.size());
	endtask

	task automatic build_programs();
		logic [31:0] r;
		// ALU funcs, LI, ADDI, forwarding chains, a no-op
		add(imm_word(OP_LI, 1, 8'h35));
		add(imm_word(OP_LI, 2, 8'hF9));  // -7
		add(alu_word(ALU_ADD, 1, 2));     // r2 from execute, r1 from writeback
		add(alu_word(ALU_SUB, 1, 2));
		add(alu_word(ALU_AND, 1, 2));
		add(alu_word(ALU_OR, 1, 2));
		add(alu_word(ALU_XOR, 1, 2));
		add(16'h9123);                    // Unused opcode
		add(imm_word(OP_ADDI, 1, 8'h64));
		add(imm_word(OP_LI, 4, 8'h03));
		add(alu_word(ALU_SLL, 1, 4));
		add(alu_word(ALU_SRL, 1, 4));
		add(alu_word(ALU_SLT, 2, 1));
		add(imm_word(OP_LI, 5, 8'h80));
		add(alu_word(ALU_SLT, 5, 2));     // Signed, -128 < 1
		add(alu_word(ALU_XOR, 5, 1));
		add(16'hF000);
		add(imm_word(OP_LI, 6, 8'h01));  // Past HALT
		end_program();
		// Stores, loads and load-use stalls
		add(imm_word(OP_LI, 1, 8'h7A));
		add(imm_word(OP_LI, 2, 8'h04));
		add(rri_word(OP_SW, 1, 2, 4'h1));
		add(rri_word(OP_LW, 3, 2, 4'h1));
		add(alu_word(ALU_ADD, 3, 3));     // Stalls one cycle
		add(rri_word(OP_SW, 3, 2, 4'hE));
		add(rri_word(OP_LW, 4, 2, 4'hE));
		add(imm_word(OP_ADDI, 4, 8'h01));
		add(rri_word(OP_LW, 5, 2, 4'h1));
		add(rri_word(OP_SW, 5, 4, 4'h0)); // Loaded store data
		add(rri_word(OP_LW, 6, 4, 4'h0));
		add(rri_word(OP_LW, 8, 6, 4'h8)); // Loaded base
		add(16'hF000);
		add(imm_word(OP_LI, 9, 8'h01));
		end_program();
		// Branches taken and not, loop with backward jump
		add(imm_word(OP_LI, 1, 8'h05));
		add(imm_word(OP_LI, 2, 8'h05));
		add(rri_word(OP_BEQ, 1, 2, 4'h1));
		add(imm_word(OP_LI, 7, 8'h11));
		add(imm_word(OP_ADDI, 2, 8'h01));
		add(rri_word(OP_BEQ, 1, 2, 4'h1));
		add(rri_word(OP_BNE, 1, 2, 4'h1));
		add(imm_word(OP_LI, 7, 8'h22));
		add(imm_word(OP_ADDI, 1, 8'h01));
		add(rri_word(OP_BNE, 1, 2, 4'h1));
		add(imm_word(OP_LI, 4, 8'h00));
		add(imm_word(OP_LI, 3, 8'h03));
		add(imm_word(OP_ADDI, 3, 8'hFF)); // Loop body
		add(rri_word(OP_BEQ, 3, 4, 4'h1));
		add(jmp_word(12'hFFD));           // Back to the body
		add(jmp_word(12'h001));
		add(imm_word(OP_LI, 7, 8'h33));
		add(16'hF000);
		add(imm_word(OP_LI, 7, 8'h44));
		end_program();
		// Random mix of 40 LI, ADDI and ALU
		for (int i = 0; i < 4; i++) begin
			r = next_random();
			add(imm_word(OP_LI, reg_addr_t'(i), r[7:0]));
		end
		for (int i = 0; i < 36; i++) begin
			r = next_random();
			if (r[31:30] == 2'd0)
				add(imm_word(OP_LI, {1'b0, r[10:8]}, r[23:16]));
			else if (r[31:30] == 2'd1)
				add(imm_word(OP_ADDI, {1'b0, r[10:8]}, r[23:16]));
			else
				add(alu_word({1'b0, r[14:12]}, {1'b0, r[10:8]}, {1'b0, r[6:4]}));
		end
		add(16'hF000);
		end_program();
	endtask

	function automatic uword alu_model(logic [3:0] func, uword a, uword b);
		case (func)
			4'd0:    return a + b;
			4'd1:    return a - b;
			4'd2:    return a & b;
			4'd3:    return a | b;
			4'd4:    return a ^ b;
			4'd5:    return a << b[3:0];
			4'd6:    return a >> b[3:0];
			4'd7:    return ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
			default: return a;
		endcase
	endfunction

	// Sequential instruction-set model, fresh state as after reset
	task automatic run_model(int first, int last);
		instr_t    prog [PROG_DEPTH];
		uword      regs [16];
		uword      dmem [DATA_DEPTH];
		uword      pc;
		uword      next_pc;
		uword      addr;
		uword      value;
		instr_t    ir;
		reg_addr_t r1;
		reg_addr_t r2;
		logic      wr;
		logic      done;
		int        steps;
		int        writes;
		for (int i = 0; i < PROG_DEPTH; i++)
			prog[i] = '0;
		for (int i = 0; i < 16; i++)
			regs[i] = '0;
		for (int i = 0; i < DATA_DEPTH; i++)
			dmem[i] = '0;
		for (int i = first; i < last; i++)
			prog[PA_W'(i - first)] = prog_words[i];
		pc     = '0;
		done   = 1'b0;
		steps  = 0;
		writes = 0;
		while (!done && steps < STEP_LIMIT) begin
			ir      = prog[pc[PA_W:1]];    // Word index of the byte PC
			r1      = ir[11:8];
			r2      = ir[7:4];
			next_pc = pc + 16'd2;
			addr    = regs[r2] + 16'($signed(ir[3:0]));
			value   = '0;
			wr      = 1'b0;
			case (ir[15:12])
				OP_ALU: begin
					wr    = !ir[3];
					value = alu_model(ir[3:0], regs[r1], regs[r2]);
				end
				OP_LI: begin
					wr    = 1'b1;
					value = 16'($signed(ir[7:0]));
				end
				OP_ADDI: begin
					wr    = 1'b1;
					value = regs[r1] + 16'($signed(ir[7:0]));
				end
				OP_LW: begin
					wr    = 1'b1;
					value = dmem[addr[DA_W-1:0]];
				end
				OP_SW: begin
					dmem[addr[DA_W-1:0]] = regs[r1];
					checker_i.expect_store(addr, regs[r1]);
				end
				OP_BEQ: if (regs[r1] == regs[r2])
					next_pc = pc + 16'd2 + 16'(2 * $signed(ir[3:0]));
				OP_BNE: if (regs[r1] != regs[r2])
					next_pc = pc + 16'd2 + 16'(2 * $signed(ir[3:0]));
				OP_JMP:  next_pc = pc + 16'd2 + 16'(2 * $signed(ir[11:0]));
				OP_HALT: done = 1'b1;
				default: ;
			endcase
			if (wr) begin
				regs[r1] = value;
				checker_i.expect_write(r1, value);
				writes++;
			end
			pc = next_pc;
			steps++;
		end
		if (!done) begin
			other_errors++;
			$display("Model of program at word %0d never reached HALT", first);
		end
		checker_i.expect_write_count(writes);
	endtask

	// Load, model, run to halt, drain, then reset
	task automatic run_program(int first, int last);
		int cycles;
		checker_i.clear_expected();
		for (int i = first; i < last; i++) begin
			@(negedge clk);
			prog_we    = 1'b1;
			prog_addr  = PA_W'(i - first);
			prog_wdata = prog_words[i];
		end
		@(negedge clk);
		prog_we = 1'b0;
		run_model(first, last);
		run    = 1'b1;
		cycles = 0;
		while (!halted && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (!halted) begin
			other_errors++;
			$display("Timeout: program at word %0d never raised halted", first);
		end
		repeat (2) @(negedge clk);          // Older instructions drain
		@(posedge clk);
		checker_i.check_complete();
		@(negedge clk);
		run   = 1'b0;
		rst_n = 1'b0;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
	endtask

	initial begin
		int first;
		int asrt;
		int total;
		rst_n      = 1'b0;
		run        = 1'b0;
		prog_we    = 1'b0;
		prog_addr  = '0;
		prog_wdata = '0;
		build_programs();
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		for (int p = 0; p < prog_ends.size(); p++) begin
			first = (p == 0) ? 0 : prog_ends[p-1];
			run_program(first, prog_ends[p]);
		end
		asrt = cpu16_top_i.asrt_i.stall_fails + cpu16_top_i.asrt_i.port_fails
			+ cpu16_top_i.asrt_i.pc_fails + cpu16_top_i.asrt_i.halt_fails;
		total = checker_i.mismatches + checker_i.missing + checker_i.extra
			+ checker_i.count_errors + other_errors + asrt;
		$display("Errors: mismatch %0d, missing %0d, extra %0d, count %0d, other %0d, assert %0d",
			checker_i.mismatches, checker_i.missing, checker_i.extra,
			checker_i.count_errors, other_errors, asrt);
		if (total == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* cpu16.f */
cpu16_pkg.sv
cpu16_alu.sv
cpu16_fetch.sv
cpu16_regfile.sv
cpu16_hazard.sv
cpu16_decode.sv
cpu16_execute.sv
cpu16_memwb.sv
cpu16_top.sv
cpu16_checker.sv
cpu16_assertions.sv
cpu16_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the cpu16 testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module cpu16_tb -f cpu16.f -o cpu16_sim
./obj_dir/cpu16_sim +verilator+error+limit+100 | tee sim.log

if grep -q "^TESTBENCH PASSED$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed, see sim.log"
	exit 1
fi
